// ==== filelist.f ====
+incdir+rtl
+incdir+verif
rtl/replayQueuePkg.sv
rtl/replayRecorder.sv
rtl/replayStorage.sv
rtl/replayGate.sv
rtl/replayFlushFilter.sv
rtl/replayQueue.sv
verif/replayQueueTb.sv

// ==== Bender.yml ====
package:
  name: replay_queue

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/replayQueuePkg.sv
      - rtl/replayRecorder.sv
      - rtl/replayStorage.sv
      - rtl/replayGate.sv
      - rtl/replayFlushFilter.sv
      - rtl/replayQueue.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/replayQueueTb.sv

// ==== verif/replayQueueTests.svh ====
// Directed tests and stimulus helpers for the replay queue testbench
// Included into the testbench module body; every task starts and ends 1 ns
// after a rising edge, where inputs are driven and outputs are read

`ifndef REPLAY_QUEUE_TESTS_SVH
`define REPLAY_QUEUE_TESTS_SVH

task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    checkCount++;
    assert (actual === expected) else begin
        $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, actual, expected);
        errorCount++;
    end
endtask

task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    $display("%s: done, %0d errors", name, errorCount - errorsBefore);
endtask

function automatic logic [`RQ_PAYLOAD_WIDTH-1:0] randomPayload();
    return `RQ_PAYLOAD_WIDTH'($random(seed));
endfunction

function automatic rqRecordT makeIntRecord(alPtrT ptr, logic [`RQ_PAYLOAD_WIDTH-1:0] pay);
    rqRecordT rec;
    rec = '0;
    rec.intValid[0] = 1'b1;
    rec.intOp[0].activeListPtr = ptr;
    rec.intOp[0].payload = pay;
    return rec;
endfunction

function automatic rqRecordT makeLoadRecord(alPtrT ptr, logic [`RQ_PAYLOAD_WIDTH-1:0] pay,
                                            mshrIdT id);
    rqRecordT rec;
    rec = '0;
    rec.memValid[0] = 1'b1;
    rec.memOp[0].activeListPtr = ptr;
    rec.memOp[0].payload = pay;
    rec.memOp[0].isLoad = 1'b1;
    rec.memOp[0].hasAllocatedMshr = 1'b1;
    rec.memOp[0].mshrId = id;
    return rec;
endfunction

// Circular range, head inclusive and tail exclusive
function automatic logic isFlushed(alPtrT head, alPtrT tail, alPtrT ptr);
    alPtrT span;
    alPtrT offset;
    span = tail - head;
    offset = ptr - head;
    return offset < span;
endfunction

task automatic stepCycle(input rqRecordT rec);
    record = rec;
    @(posedge clk);
    #1;
    record = '0;
endtask

task automatic idleCycles(input int n);
    repeat (n) stepCycle('0);
endtask

task automatic clearLogs();
    obsRec.delete();
    obsCycle.delete();
    obsFlush.delete();
    relMask.delete();
    relCycle.delete();
endtask

task automatic waitReplays(input int n, output bit arrived);
    int waited;
    waited = 0;
    while ((obsRec.size() < n) && (waited < DRAIN_LIMIT)) begin
        idleCycles(1);
        waited++;
    end
    arrived = (obsRec.size() >= n);
    if (!arrived) begin
        $display("timeout: only %0d of %0d replays arrived", obsRec.size(), n);
        errorCount++;
    end
endtask

task automatic drainQueue();
    int waited;
    waited = 0;
    while ((u_dut.count != '0) && (waited < DRAIN_LIMIT)) begin
        idleCycles(1);
        waited++;
    end
    if (u_dut.count != '0) begin
        $display("timeout: the queue did not drain");
        errorCount++;
    end
    idleCycles(2);
endtask

task automatic resetValuesTest();
    int errorsBefore;
    errorsBefore = errorCount;
    for (int i = 0; i < 4; i++) begin
        checkValue(replay, 1'b0, "replay after reset");
        checkValue(stallUpper, 1'b0, "stallUpper after reset");
        checkValue(flushedOpExist, 1'b0, "flushedOpExist after reset");
        checkValue(mshrRelease, '0, "mshrRelease after reset");
        checkValue({replayed.intValid, replayed.memValid}, '0, "replayed valid after reset");
        idleCycles(1);
    end
    reportTest("reset values", errorsBefore);
endtask

task automatic orderSpacingTest();
    int errorsBefore;
    int gaps [4] = '{1, 3, 2, 7};
    int expGap;
    rqRecordT sent [$];
    bit arrived;
    errorsBefore = errorCount;
    clearLogs();
    for (int i = 0; i < 5; i++) begin
        sent.push_back(makeIntRecord(alPtrT'(i + 1), randomPayload()));
    end
    stepCycle(sent[0]);
    for (int i = 0; i < 4; i++) begin
        idleCycles(gaps[i] - 1);
        stepCycle(sent[i + 1]);
    end
    waitReplays(5, arrived);
    if (arrived) begin
        for (int i = 0; i < 5; i++) begin
            checkValue(obsRec[i].intOp[0].payload, sent[i].intOp[0].payload, "replay order");
            checkValue(obsRec[i].intValid[0], 1'b1, "replayed int valid");
        end
        for (int i = 0; i < 4; i++) begin
            expGap = (gaps[i] > `RQ_MAX_INTERVAL) ? `RQ_MAX_INTERVAL : gaps[i];
            checkValue(obsCycle[i + 1] - obsCycle[i], expGap, "replay spacing");
        end
    end
    drainQueue();
    reportTest("order and spacing", errorsBefore);
endtask

task automatic loadHoldTest();
    int errorsBefore;
    int releaseCycle;
    rqRecordT sent [$];
    bit arrived;
    errorsBefore = errorCount;
    clearLogs();
    mshrStatus[1].ready = 1'b0;
    sent.push_back(makeLoadRecord(6'd20, randomPayload(), 2'd1));
    sent.push_back(makeIntRecord(6'd21, randomPayload()));
    sent.push_back(makeIntRecord(6'd22, randomPayload()));
    stepCycle(sent[0]);
    idleCycles(1);
    stepCycle(sent[1]);
    idleCycles(2);
    stepCycle(sent[2]);
    idleCycles(4);
    checkValue(obsRec.size(), 0, "replay while the head load waits");
    mshrStatus[1].ready = 1'b1;
    releaseCycle = cycleNum;
    waitReplays(3, arrived);
    if (arrived) begin
        checkValue(obsCycle[0] > releaseCycle, 1'b1, "load replayed after MSHR ready");
        checkValue(obsRec[0].memValid[0], 1'b1, "replayed load valid");
        checkValue(obsRec[0].memOp[0].payload, sent[0].memOp[0].payload, "load payload");
        checkValue(obsRec[1].intOp[0].payload, sent[1].intOp[0].payload, "second payload");
        checkValue(obsRec[2].intOp[0].payload, sent[2].intOp[0].payload, "third payload");
        checkValue(obsCycle[1] - obsCycle[0], 2, "spacing after hold");
        checkValue(obsCycle[2] - obsCycle[1], 3, "spacing after hold");
    end
    drainQueue();
    reportTest("load hold", errorsBefore);
endtask

task automatic stallThresholdTest();
    int errorsBefore;
    errorsBefore = errorCount;
    mshrStatus[0].ready = 1'b0;
    // Head stays held, so the queue holds exactly the records pushed so far
    for (int k = 1; k <= `RQ_ENTRY_NUM - 2; k++) begin
        if (k == 1) begin
            stepCycle(makeLoadRecord(6'd30, randomPayload(), 2'd0));
        end else begin
            stepCycle(makeIntRecord(alPtrT'(30 + k), randomPayload()));
        end
        checkValue(replay, 1'b0, "replay while the head load waits");
        checkValue(stallUpper, k >= (`RQ_ENTRY_NUM - `RQ_MEM_LATENCY), "stallUpper level");
    end
    mshrStatus[0].ready = 1'b1;
    drainQueue();
    reportTest("stall threshold", errorsBefore);
endtask

task automatic selectiveFlushTest();
    int errorsBefore;
    int flushCapture;
    int expRelCycle;
    logic [`RQ_MSHR_NUM-1:0] expRel;
    logic flushed;
    rqRecordT sent [$];
    bit arrived;
    errorsBefore = errorCount;
    clearLogs();
    expRel = '0;
    expRelCycle = 0;
    mshrStatus[1].ready = 1'b0;
    mshrStatus[2].ready = 1'b1;
    sent.push_back(makeLoadRecord(6'd10, randomPayload(), 2'd1));
    sent.push_back(makeIntRecord(6'd11, randomPayload()));
    sent.push_back(makeIntRecord(6'd12, randomPayload()));
    sent.push_back(makeIntRecord(6'd13, randomPayload()));
    sent.push_back(makeLoadRecord(6'd14, randomPayload(), 2'd2));
    foreach (sent[i]) begin
        stepCycle(sent[i]);
    end
    flushCapture = sent.size();
    flushReq = '{recovery: 1'b1, rangeHead: 6'd12, rangeTail: 6'd15};
    stepCycle('0);
    flushReq = '0;
    checkValue(flushedOpExist, 1'b1, "flushedOpExist after recovery");
    idleCycles(1);
    mshrStatus[1].ready = 1'b1;
    waitReplays(flushCapture, arrived);
    if (arrived) begin
        for (int i = 0; i < flushCapture; i++) begin
            checkValue(obsFlush[i], 1'b1, "flushedOpExist during flushed replays");
            if (sent[i].intValid[0]) begin
                flushed = isFlushed(6'd12, 6'd15, sent[i].intOp[0].activeListPtr);
                checkValue(obsRec[i].intValid[0], !flushed, "int valid after flush");
                checkValue(obsRec[i].intOp[0].payload, sent[i].intOp[0].payload, "int order");
            end else begin
                flushed = isFlushed(6'd12, 6'd15, sent[i].memOp[0].activeListPtr);
                checkValue(obsRec[i].memValid[0], !flushed, "mem valid after flush");
                checkValue(obsRec[i].memOp[0].payload, sent[i].memOp[0].payload, "mem order");
                if (flushed) begin
                    expRel[sent[i].memOp[0].mshrId] = 1'b1;
                    expRelCycle = obsCycle[i];
                end
            end
        end
        checkValue(relMask.size(), 1, "number of MSHR release pulses");
        if (relMask.size() == 1) begin
            checkValue(relMask[0], expRel, "released MSHR");
            checkValue(relCycle[0], expRelCycle, "release in the output cycle");
        end
        checkValue(flushedOpExist, 1'b0, "flushedOpExist after the captured count");
    end
    drainQueue();
    reportTest("selective flush", errorsBefore);
endtask

`endif

// ==== verif/replayQueueTb.sv ====
// Testbench top for the replay queue
// Owns clock, reset, the DUT and a negedge monitor that logs every replay
// pulse and MSHR release; the directed tests come from the included header

`default_nettype none

`include "replayQueue_consts.svh"

module replayQueueTb import replayQueuePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Cycle budgets per test, drains included
    localparam int DRAIN_LIMIT = 4 * `RQ_ENTRY_NUM;
    localparam int RESET_BUDGET = 10;
    localparam int ORDER_BUDGET = 60 + DRAIN_LIMIT;
    localparam int HOLD_BUDGET = 60 + DRAIN_LIMIT;
    localparam int STALL_BUDGET = 2 * `RQ_ENTRY_NUM + 2 * DRAIN_LIMIT;
    localparam int FLUSH_BUDGET = 40 + 2 * DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = RESET_BUDGET + ORDER_BUDGET + HOLD_BUDGET
        + STALL_BUDGET + FLUSH_BUDGET;

    logic clk;
    logic arstN;
    rqRecordT record;
    mshrStatusT mshrStatus [`RQ_MSHR_NUM];
    flushReqT flushReq;
    rqRecordT replayed;
    logic replay;
    logic stallUpper;
    logic flushedOpExist;
    logic [`RQ_MSHR_NUM-1:0] mshrRelease;

    int seed;
    int cycleNum = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;

    // Monitor logs
    rqRecordT obsRec [$];
    int obsCycle [$];
    logic obsFlush [$];
    logic [`RQ_MSHR_NUM-1:0] relMask [$];
    int relCycle [$];

    replayQueue u_dut (
        .clk            (clk),
        .arstN          (arstN),
        .record         (record),
        .mshrStatus     (mshrStatus),
        .flushReq       (flushReq),
        .replayed       (replayed),
        .replay         (replay),
        .stallUpper     (stallUpper),
        .flushedOpExist (flushedOpExist),
        .mshrRelease    (mshrRelease)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleNum <= cycleNum + 1;
    end

    // Outputs come from registers only, so mid-cycle sampling is safe
    always @(negedge clk) begin
        if (arstN && replay) begin
            obsRec.push_back(replayed);
            obsCycle.push_back(cycleNum);
            obsFlush.push_back(flushedOpExist);
        end
        if (arstN && (mshrRelease != '0)) begin
            relMask.push_back(mshrRelease);
            relCycle.push_back(cycleNum);
        end
    end

    `include "replayQueueTests.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed = 98;
        arstN = 1'b0;
        record = '0;
        flushReq = '0;
        for (int i = 0; i < `RQ_MSHR_NUM; i++) begin
            mshrStatus[i] = '{valid: 1'b0, ready: 1'b1, addrSubset: '0};
        end
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;

        resetValuesTest();
        orderSpacingTest();
        loadHoldTest();
        stallThresholdTest();
        selectiveFlushTest();

        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/replayQueue.sv ====
// Replay queue of the scheduler
// Records issued int and memory ops, replays them in order with their
// original spacing and filters ops killed by a recovery

`default_nettype none

`include "replayQueue_consts.svh"

module replayQueue import replayQueuePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  rqRecordT   record,
    input  mshrStatusT mshrStatus [`RQ_MSHR_NUM],
    input  flushReqT   flushReq,
    output rqRecordT   replayed,
    output logic       replay,
    output logic       stallUpper,
    output logic       flushedOpExist,
    output logic [`RQ_MSHR_NUM-1:0] mshrRelease
);

    logic push;
    logic pop;
    logic empty;
    logic headValid;
    rqIndexT tailPtr;
    rqIndexT headPtr;
    rqCountT count;
    rqEntryT wrEntry;
    rqEntryT headEntry;
    rqRecordT popEntry;

    replayRecorder u_recorder (
        .clk       (clk),
        .arstN     (arstN),
        .record    (record),
        .pop       (pop),
        .headValid (headValid),
        .push      (push),
        .wrEntry   (wrEntry),
        .tailPtr   (tailPtr),
        .headPtr   (headPtr),
        .count     (count),
        .empty     (empty)
    );

    replayStorage u_storage (
        .clk (clk),
        .we  (push),
        .wa  (tailPtr),
        .ra  (headPtr),
        .wv  (wrEntry),
        .rv  (headEntry)
    );

    replayGate u_gate (
        .clk        (clk),
        .arstN      (arstN),
        .headEntry  (headEntry),
        .empty      (empty),
        .mshrStatus (mshrStatus),
        .pop        (pop),
        .headValid  (headValid),
        .popEntry   (popEntry)
    );

    replayFlushFilter u_filter (
        .clk            (clk),
        .arstN          (arstN),
        .popEntry       (popEntry),
        .headValid      (headValid),
        .count          (count),
        .flushReq       (flushReq),
        .replayed       (replayed),
        .replay         (replay),
        .flushedOpExist (flushedOpExist),
        .mshrRelease    (mshrRelease),
        .stallUpper     (stallUpper)
    );

endmodule

`default_nettype wire

// ==== rtl/replayFlushFilter.sv ====
// Output stage of the replay queue
// Registers the popped ops, drops those inside a recovered range and
// tells the memory unit which MSHRs their loads may give back

`default_nettype none

`include "replayQueue_consts.svh"

module replayFlushFilter import replayQueuePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  rqRecordT popEntry,
    input  logic     headValid,
    input  rqCountT  count,
    input  flushReqT flushReq,
    output rqRecordT replayed,
    output logic     replay,
    output logic     flushedOpExist,
    output logic [`RQ_MSHR_NUM-1:0] mshrRelease,
    output logic     stallUpper
);

    rqRecordT outReg;
    rqCountT flushCount;
    alPtrT rangeHead;
    alPtrT rangeTail;
    logic flushActive;
    logic almostFull;
    logic [`RQ_INT_WIDTH-1:0] flushInt;
    logic [`RQ_MEM_WIDTH-1:0] flushMem;

    // Circular range with an inclusive head and an exclusive tail
    function automatic logic inRange(alPtrT head, alPtrT tail, alPtrT ptr);
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    // One cycle from pop to the outputs
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outReg <= '0;
            replay <= 1'b0;
        end else begin
            outReg <= popEntry;
            replay <= headValid;
        end
    end

    // Entries queued at recovery may hold flushed ops
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushCount <= '0;
        end else if (flushReq.recovery) begin
            flushCount <= count;
        end else if (flushActive && replay) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flushReq.recovery) begin
            rangeHead <= flushReq.rangeHead;
            rangeTail <= flushReq.rangeTail;
        end
    end

    assign flushActive = (flushCount != '0);
    assign flushedOpExist = flushActive;

    always_comb begin
        replayed = outReg;
        mshrRelease = '0;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            flushInt[i] = flushActive
                && inRange(rangeHead, rangeTail, outReg.intOp[i].activeListPtr);
            replayed.intValid[i] = outReg.intValid[i] && !flushInt[i];
        end
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            flushMem[i] = flushActive
                && inRange(rangeHead, rangeTail, outReg.memOp[i].activeListPtr);
            replayed.memValid[i] = outReg.memValid[i] && !flushMem[i];
            // A dropped load frees the MSHR it allocated
            if (outReg.memValid[i] && flushMem[i] && outReg.memOp[i].isLoad
                    && outReg.memOp[i].hasAllocatedMshr) begin
                mshrRelease[outReg.memOp[i].mshrId] = 1'b1;
            end
        end
    end

    // Leave room for ops already past the schedule stage
    assign almostFull = (count >= rqCountT'(`RQ_ENTRY_NUM - `RQ_MEM_LATENCY));
    assign stallUpper = replay || almostFull;

    // The flush counter never wraps and never exceeds the queue depth
    assert property (@(posedge clk) disable iff (!arstN)
        flushCount <= rqCountT'(`RQ_ENTRY_NUM))
        else $error("flush counter out of range");

endmodule

`default_nettype wire

// ==== rtl/replayGate.sv ====
// Pop decision for the head of the replay queue
// Waits out the recorded interval and holds the head while one of its
// loads depends on an MSHR that has not received data

`default_nettype none

`include "replayQueue_consts.svh"

module replayGate import replayQueuePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  rqEntryT    headEntry,
    input  logic       empty,
    input  mshrStatusT mshrStatus [`RQ_MSHR_NUM],
    output logic       pop,
    output logic       headValid,
    output rqRecordT   popEntry
);

    rqIntervalT intervalCount;
    memOpT headMem [`RQ_MEM_WIDTH];
    mshrStatusT slotStatus [`RQ_MEM_WIDTH];
    logic [`RQ_MEM_WIDTH-1:0] allocWait;
    logic [`RQ_MEM_WIDTH-1:0] hitWait;
    logic [`RQ_MEM_WIDTH-1:0] held;
    logic anyValid;
    logic intervalDone;

    // Saturating count of cycles since the last pop
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            intervalCount <= '0;
        end else if (pop) begin
            intervalCount <= '0;
        end else if (intervalCount < rqIntervalT'(`RQ_MAX_INTERVAL)) begin
            intervalCount <= intervalCount + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            headMem[i] = headEntry.record.memOp[i];
            slotStatus[i] = mshrStatus[headMem[i].mshrId];
            // Load owns the MSHR and its fill has not come back
            allocWait[i] = headMem[i].hasAllocatedMshr && !slotStatus[i].ready;
            // Load hit a pending miss that still serves the same line
            hitWait[i] = headMem[i].addrHit && slotStatus[i].valid
                && (slotStatus[i].addrSubset == headMem[i].addrSubset)
                && !slotStatus[i].ready;
            held[i] = headEntry.record.memValid[i] && headMem[i].isLoad
                && (allocWait[i] || hitWait[i]);
        end
    end

    assign anyValid = (|headEntry.record.intValid) || (|headEntry.record.memValid);
    assign intervalDone = (intervalCount >= headEntry.replayInterval);

    // Bubbles never carry loads and are never held
    assign pop = !empty && intervalDone && !(|held);
    assign headValid = pop && anyValid;

    always_comb begin
        popEntry = headEntry.record;
        popEntry.intValid = pop ? headEntry.record.intValid : '0;
        popEntry.memValid = pop ? headEntry.record.memValid : '0;
    end

    // A waiting head is never overwritten or moved
    assert property (@(posedge clk) disable iff (!arstN)
        (!empty && !pop) |=> $stable(headEntry))
        else $error("head entry changed while waiting");

endmodule

`default_nettype wire

// ==== rtl/replayStorage.sv ====
// Entry memory of the replay queue
// Written at the tail on the clock edge, read at the head without a clock

`default_nettype none

`include "replayQueue_consts.svh"

module replayStorage import replayQueuePkg::*; (
    input  logic    clk,
    input  logic    we,
    input  rqIndexT wa,
    input  rqIndexT ra,
    input  rqEntryT wv,
    output rqEntryT rv
);

    rqEntryT mem [`RQ_ENTRY_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wv;
        end
    end

    // Asynchronous read so the gate sees the head in the same cycle
    assign rv = mem[ra];

endmodule

`default_nettype wire

// ==== rtl/replayRecorder.sv ====
// Record side of the replay queue
// Decides each cycle whether the issued record is pushed, stamps the gap since
// the previous push and keeps pointers, occupancy and valid-op count

`default_nettype none

`include "replayQueue_consts.svh"

module replayRecorder import replayQueuePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  rqRecordT record,
    input  logic     pop,
    input  logic     headValid,
    output logic     push,
    output rqEntryT  wrEntry,
    output rqIndexT  tailPtr,
    output rqIndexT  headPtr,
    output rqCountT  count,
    output logic     empty
);

    logic full;
    logic recordValid;
    rqCountT validInstCount;
    rqIntervalT intervalIn;

    assign full = (count == rqCountT'(`RQ_ENTRY_NUM));
    assign empty = (count == '0);
    assign recordValid = (|record.intValid) || (|record.memValid);

    // Bubbles are kept while real ops are queued so the spacing survives
    assign push = !full && (recordValid || (validInstCount != '0));

    assign wrEntry.record = record;
    assign wrEntry.replayInterval = intervalIn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            count <= count + rqCountT'(push) - rqCountT'(pop);
        end
    end

    // headValid already implies a pop of a non-bubble entry
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validInstCount <= '0;
        end else begin
            validInstCount <= validInstCount + rqCountT'(push && recordValid)
                - rqCountT'(headValid);
        end
    end

    // Saturating count of cycles since the last push
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            intervalIn <= '0;
        end else if (push) begin
            intervalIn <= '0;
        end else if (intervalIn < rqIntervalT'(`RQ_MAX_INTERVAL)) begin
            intervalIn <= intervalIn + 1'b1;
        end
    end

    // Occupancy never goes past the depth nor wraps below zero
    assert property (@(posedge clk) disable iff (!arstN)
        count <= rqCountT'(`RQ_ENTRY_NUM))
        else $error("replay queue occupancy out of range");

    // Valid ops can never outnumber the entries holding them
    assert property (@(posedge clk) disable iff (!arstN)
        validInstCount <= count)
        else $error("valid op count exceeds occupancy");

endmodule

`default_nettype wire

// ==== rtl/replayQueuePkg.sv ====
// Types for the replay queue: micro-ops, queue entries, MSHR status and flush request
// Modules take them with a wildcard import in their header

`default_nettype none

`include "replayQueue_consts.svh"

package replayQueuePkg;

    typedef logic [$clog2(`RQ_ENTRY_NUM)-1:0] rqIndexT;
    typedef logic [$clog2(`RQ_ENTRY_NUM):0] rqCountT;
    typedef logic [$clog2(`RQ_MAX_INTERVAL + 1)-1:0] rqIntervalT;
    typedef logic [$clog2(`RQ_MSHR_NUM)-1:0] mshrIdT;
    typedef logic [`RQ_AL_PTR_WIDTH-1:0] alPtrT;

    typedef struct packed {
        alPtrT activeListPtr;
        logic [`RQ_PAYLOAD_WIDTH-1:0] payload;
    } intOpT;

    typedef struct packed {
        alPtrT activeListPtr;
        logic [`RQ_PAYLOAD_WIDTH-1:0] payload;
        logic isLoad;
        logic hasAllocatedMshr;
        mshrIdT mshrId;
        // Load hit an in-flight MSHR at issue time
        logic addrHit;
        logic [`RQ_SUBSET_WIDTH-1:0] addrSubset;
    } memOpT;

    // Everything issued in one cycle
    typedef struct packed {
        logic [`RQ_INT_WIDTH-1:0] intValid;
        intOpT [`RQ_INT_WIDTH-1:0] intOp;
        logic [`RQ_MEM_WIDTH-1:0] memValid;
        memOpT [`RQ_MEM_WIDTH-1:0] memOp;
    } rqRecordT;

    typedef struct packed {
        rqRecordT record;
        rqIntervalT replayInterval;
    } rqEntryT;

    typedef struct packed {
        logic valid;
        logic ready;
        logic [`RQ_SUBSET_WIDTH-1:0] addrSubset;
    } mshrStatusT;

    typedef struct packed {
        logic recovery;
        alPtrT rangeHead;
        alPtrT rangeTail;
    } flushReqT;

endpackage

`default_nettype wire

// ==== rtl/replayQueue_consts.svh ====
// Sizes and widths shared by the replay queue RTL and its testbench
// Include wherever a size is needed; the guard keeps repeated includes harmless

`ifndef REPLAY_QUEUE_CONSTS_SVH
`define REPLAY_QUEUE_CONSTS_SVH

// Queue depth, kept a power of two so the pointers wrap on their own
`define RQ_ENTRY_NUM 16

// Issue slots recorded per cycle
`define RQ_INT_WIDTH 2
`define RQ_MEM_WIDTH 2

`define RQ_MSHR_NUM 4

// Op fields
`define RQ_AL_PTR_WIDTH 6
`define RQ_SUBSET_WIDTH 4
`define RQ_PAYLOAD_WIDTH 16

// Longest gap stamped into an entry
`define RQ_MAX_INTERVAL 7

// Entries that may still arrive after the stall is raised
`define RQ_MEM_LATENCY 4

`endif
